//--- hdl/soc_mem_pkg.sv
package soc_mem_pkg;

   // word and lane geometry
   localparam int ADDR_W  = 8;
   localparam int DATA_W  = 32;
   localparam int COL_W   = 8;
   localparam int NUM_COL = 4;

   localparam int MEM_WORDS  = 256;
   localparam int BOOT_WORDS = 16;

   // xor key of the boot image bytes
   localparam logic [COL_W-1:0] BOOT_KEY = 8'h5A;

   typedef enum logic [1:0] {
      BOOT_COPY,
      BOOT_LAST,
      BOOT_DONE
   } boot_state_e;

   typedef enum logic [1:0] {
      HOST_IDLE,
      HOST_WAIT,
      HOST_RESP
   } host_state_e;

   typedef enum logic {
      OWN_BOOT,
      OWN_HOST
   } arb_owner_e;

   // lane k of word idx holds (NUM_COL*idx + k) ^ key, lane 0 is the low byte
   function automatic logic [DATA_W-1:0] boot_word(input int unsigned idx);
      logic [DATA_W-1:0] word;
      word = '0;
      for (int k = 0; k < NUM_COL; k++) begin
         word[k*COL_W +: COL_W] = COL_W'(NUM_COL * idx + k) ^ BOOT_KEY;
      end
      return word;
   endfunction

endpackage

//--- hdl/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if
   import soc_mem_pkg::*;
();

   logic                req;
   logic [NUM_COL-1:0]  wstrb;
   logic [ADDR_W-1:0]   addr;
   logic [DATA_W-1:0]   wdata;
   logic                gnt;
   logic                rvalid;
   logic [DATA_W-1:0]   rdata;

   // requester side
   modport master (
      output req, wstrb, addr, wdata,
      input  gnt, rvalid, rdata
   );

   // arbiter side of a peer link
   modport slave (
      input  req, wstrb, addr, wdata,
      output gnt, rvalid, rdata
   );

   // req acts as the memory enable
   modport ram (
      input  req, wstrb, addr, wdata,
      output rdata
   );

endinterface

//--- hdl/byte_ram_sp.sv
`timescale 1ns/1ns

module byte_ram_sp
   import soc_mem_pkg::*;
(
   input logic    clk_i,
   mem_bus_if.ram ram
);

   logic [DATA_W-1:0] mem [MEM_WORDS];

   // read-first: rdata gets the word as it was before this edge's write
   always_ff @(posedge clk_i) begin
      if (ram.req) begin
         for (int k = 0; k < NUM_COL; k++) begin
            if (ram.wstrb[k]) begin
               mem[ram.addr][k*COL_W +: COL_W] <= ram.wdata[k*COL_W +: COL_W];
            end
         end
         ram.rdata <= mem[ram.addr];
      end
   end

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter
   import soc_mem_pkg::*;
(
   input logic       clk_i,
   input logic       reset_i,
   mem_bus_if.slave  boot_bus,
   mem_bus_if.slave  host_bus,
   mem_bus_if.master ram
);

   arb_owner_e owner_q;
   logic       rvalid_q;
   logic       boot_gnt;
   logic       host_gnt;

   // round robin, the peer not granted last wins a tie
   always_comb begin
      boot_gnt = 1'b0;
      host_gnt = 1'b0;
      if (boot_bus.req && host_bus.req) begin
         if (owner_q == OWN_BOOT) begin
            host_gnt = 1'b1;
         end else begin
            boot_gnt = 1'b1;
         end
      end else begin
         boot_gnt = boot_bus.req;
         host_gnt = host_bus.req;
      end
   end

   assign boot_bus.gnt = boot_gnt;
   assign host_bus.gnt = host_gnt;

   assign ram.req   = boot_gnt | host_gnt;
   assign ram.addr  = host_gnt ? host_bus.addr : boot_bus.addr;
   assign ram.wstrb = host_gnt ? host_bus.wstrb : boot_bus.wstrb;
   assign ram.wdata = host_gnt ? host_bus.wdata : boot_bus.wdata;

   // owner only moves on a grant, so it also tags the access in flight
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         owner_q  <= OWN_HOST;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= boot_gnt | host_gnt;
         if (boot_gnt) begin
            owner_q <= OWN_BOOT;
         end else if (host_gnt) begin
            owner_q <= OWN_HOST;
         end
      end
   end

   assign boot_bus.rvalid = rvalid_q && (owner_q == OWN_BOOT);
   assign host_bus.rvalid = rvalid_q && (owner_q == OWN_HOST);
   assign boot_bus.rdata  = ram.rdata;
   assign host_bus.rdata  = ram.rdata;

   a_one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
      !(boot_bus.gnt && host_bus.gnt));

   a_boot_resp: assert property (@(posedge clk_i) disable iff (reset_i)
      boot_bus.gnt |=> boot_bus.rvalid);

   a_host_resp: assert property (@(posedge clk_i) disable iff (reset_i)
      host_bus.gnt |=> host_bus.rvalid);

endmodule

//--- hdl/boot_copier.sv
`timescale 1ns/1ns

module boot_copier
   import soc_mem_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   mem_bus_if.master bus,
   output logic      boot_done_o
);

   boot_state_e       state_q;
   logic [ADDR_W-1:0] addr_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= BOOT_COPY;
         addr_q  <= '0;
      end else begin
         case (state_q)
            BOOT_COPY: begin
               if (bus.gnt) begin
                  addr_q <= addr_q + 1'b1;
                  // next word is the final one
                  if (addr_q == ADDR_W'(BOOT_WORDS - 2)) begin
                     state_q <= BOOT_LAST;
                  end
               end
            end
            BOOT_LAST: begin
               if (bus.gnt) begin
                  state_q <= BOOT_DONE;
               end
            end
            default: begin
               state_q <= BOOT_DONE;
            end
         endcase
      end
   end

   // requests start in the first cycle out of reset
   assign bus.req   = !reset_i && (state_q != BOOT_DONE);
   // rom is the package rule evaluated at the current address
   assign bus.addr  = addr_q;
   assign bus.wstrb = '1;
   assign bus.wdata = boot_word(addr_q);

   assign boot_done_o = (state_q == BOOT_DONE);

   a_idle_when_done: assert property (@(posedge clk_i) disable iff (reset_i)
      (state_q == BOOT_DONE) |-> !bus.req);

endmodule

//--- hdl/host_port.sv
`timescale 1ns/1ns

module host_port
   import soc_mem_pkg::*;
(
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               host_valid_i,
   input  logic [ADDR_W-1:0]  host_addr_i,
   input  logic [DATA_W-1:0]  host_wdata_i,
   input  logic [NUM_COL-1:0] host_wstrb_i,
   mem_bus_if.master          bus,
   output logic               host_busy_o,
   output logic               host_done_o,
   output logic [DATA_W-1:0]  host_rdata_o
);

   host_state_e        state_q;
   logic [ADDR_W-1:0]  addr_q;
   logic [DATA_W-1:0]  wdata_q;
   logic [NUM_COL-1:0] wstrb_q;
   logic               accept;

   // busy already low in the response cycle, so a new strobe fits there
   assign host_busy_o = (state_q == HOST_WAIT) || (state_q == HOST_RESP && !bus.rvalid);
   assign host_done_o = (state_q == HOST_RESP) && bus.rvalid;
   assign accept      = host_valid_i && !host_busy_o;

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q  <= host_addr_i;
         wdata_q <= host_wdata_i;
         wstrb_q <= host_wstrb_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= HOST_IDLE;
      end else begin
         case (state_q)
            HOST_IDLE: if (accept) state_q <= HOST_WAIT;
            HOST_WAIT: if (bus.gnt) state_q <= HOST_RESP;
            HOST_RESP: begin
               if (bus.rvalid) begin
                  state_q <= accept ? HOST_WAIT : HOST_IDLE;
               end
            end
            default: state_q <= HOST_IDLE;
         endcase
      end
   end

   assign bus.req   = (state_q == HOST_WAIT);
   assign bus.addr  = addr_q;
   assign bus.wdata = wdata_q;
   assign bus.wstrb = wstrb_q;

   assign host_rdata_o = bus.rdata;

   a_no_strobe_busy: assert property (@(posedge clk_i) disable iff (reset_i)
      host_busy_o |-> !host_valid_i);

endmodule

//--- hdl/soc_mem_top.sv
`timescale 1ns/1ns

module soc_mem_top
   import soc_mem_pkg::*;
(
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               host_valid_i,
   input  logic [ADDR_W-1:0]  host_addr_i,
   input  logic [DATA_W-1:0]  host_wdata_i,
   input  logic [NUM_COL-1:0] host_wstrb_i,
   output logic               boot_done_o,
   output logic               host_busy_o,
   output logic               host_done_o,
   output logic [DATA_W-1:0]  host_rdata_o
);

   mem_bus_if boot_bus ();
   mem_bus_if host_bus ();
   mem_bus_if ram_bus ();

   boot_copier u_boot_copier (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .bus         (boot_bus),
      .boot_done_o (boot_done_o)
   );

   host_port u_host_port (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .host_valid_i (host_valid_i),
      .host_addr_i  (host_addr_i),
      .host_wdata_i (host_wdata_i),
      .host_wstrb_i (host_wstrb_i),
      .bus          (host_bus),
      .host_busy_o  (host_busy_o),
      .host_done_o  (host_done_o),
      .host_rdata_o (host_rdata_o)
   );

   mem_arbiter u_mem_arbiter (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .boot_bus (boot_bus),
      .host_bus (host_bus),
      .ram      (ram_bus)
   );

   byte_ram_sp u_byte_ram_sp (
      .clk_i (clk_i),
      .ram   (ram_bus)
   );

endmodule

//--- bench/soc_mem_tb.sv
`timescale 1ns/1ns

module soc_mem_tb
   import soc_mem_pkg::*;
();

   localparam int N_FULL       = 24;
   localparam int N_BYTE       = 24;
   localparam int N_CONT       = 12;
   localparam int N_RANDOM     = 300;
   localparam int NUM_OPS      = 2 * BOOT_WORDS + 2 * N_FULL + 2 * N_BYTE + N_CONT + N_RANDOM + 2;
   localparam int TIMEOUT_NS   = NUM_OPS * (BOOT_WORDS + 4) * 10 + 2000;
   localparam int ACCESS_LIMIT = 4 * BOOT_WORDS;

   logic               clk_i;
   logic               reset_i;
   logic               host_valid_i;
   logic [ADDR_W-1:0]  host_addr_i;
   logic [DATA_W-1:0]  host_wdata_i;
   logic [NUM_COL-1:0] host_wstrb_i;
   logic               boot_done_o;
   logic               host_busy_o;
   logic               host_done_o;
   logic [DATA_W-1:0]  host_rdata_o;

   // reference memory and which words hold defined data
   logic [DATA_W-1:0] model [MEM_WORDS];
   logic              known [MEM_WORDS];
   logic [ADDR_W-1:0] full_addr [N_FULL];
   logic [31:0]       lfsr_q;
   int                error_count;

   soc_mem_top UUT (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .host_valid_i (host_valid_i),
      .host_addr_i  (host_addr_i),
      .host_wdata_i (host_wdata_i),
      .host_wstrb_i (host_wstrb_i),
      .boot_done_o  (boot_done_o),
      .host_busy_o  (host_busy_o),
      .host_done_o  (host_done_o),
      .host_rdata_o (host_rdata_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // byte k of boot word i is (4i + k) xor 5A
   function automatic logic [DATA_W-1:0] expected_boot_word(input int idx);
      logic [DATA_W-1:0] w;
      for (int k = 0; k < NUM_COL; k++) begin
         w[k*COL_W +: COL_W] = 8'(4 * idx + k) ^ 8'h5A;
      end
      return w;
   endfunction

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
         val = {val[30:0], lfsr_q[0]};
      end
      return val;
   endfunction

   task automatic rand_high_addr(output logic [ADDR_W-1:0] addr);
      logic [31:0] r;
      r = rand_bits(ADDR_W);
      addr = r[ADDR_W-1:0];
      if (addr < ADDR_W'(BOOT_WORDS)) begin
         addr = addr + ADDR_W'(BOOT_WORDS);
      end
   endtask

   task automatic stop_on_error();
      error_count++;
      $display("tests failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("ERR %s: actual 0x%h expected 0x%h", name, actual, expected);
         stop_on_error();
      end
   endtask

   task automatic check_idle_outputs();
      check("boot_done_o", 32'(boot_done_o), 32'h0);
      check("host_busy_o", 32'(host_busy_o), 32'h0);
      check("host_done_o", 32'(host_done_o), 32'h0);
   endtask

   task automatic load_boot_model();
      for (int i = 0; i < BOOT_WORDS; i++) begin
         model[i] = expected_boot_word(i);
         known[i] = 1'b1;
      end
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      #1;
      reset_i      = 1'b1;
      host_valid_i = 1'b0;
      repeat (3) begin
         @(posedge clk_i);
         @(negedge clk_i);
         check_idle_outputs();
      end
      @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      @(negedge clk_i);
      check_idle_outputs();
   endtask

   task automatic wait_boot_done(input int limit);
      int cycles;
      cycles = 0;
      while (!boot_done_o) begin
         @(negedge clk_i);
         cycles++;
         if (cycles > limit && !boot_done_o) begin
            $display("boot_done_o did not rise within %0d cycles", limit);
            stop_on_error();
         end
      end
   endtask

   // busy must hold from the strobe until the single done pulse
   task automatic host_access(input logic [ADDR_W-1:0] addr, input logic [NUM_COL-1:0] wstrb,
                              input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
      int   cycles;
      logic done_seen;
      @(posedge clk_i);
      #1;
      host_valid_i = 1'b1;
      host_addr_i  = addr;
      host_wstrb_i = wstrb;
      host_wdata_i = wdata;
      @(negedge clk_i);
      check("host_busy_o", 32'(host_busy_o), 32'h0);
      check("host_done_o", 32'(host_done_o), 32'h0);
      @(posedge clk_i);
      #1;
      host_valid_i = 1'b0;
      cycles    = 0;
      done_seen = 1'b0;
      while (!done_seen) begin
         @(negedge clk_i);
         cycles++;
         if (host_done_o) begin
            done_seen = 1'b1;
         end else begin
            check("host_busy_o", 32'(host_busy_o), 32'h1);
            if (cycles > ACCESS_LIMIT) begin
               $display("host access to address %0h never finished", addr);
               stop_on_error();
            end
         end
      end
      check("host_busy_o", 32'(host_busy_o), 32'h0);
      if (cycles < 2) begin
         $display("host access to address %0h finished after %0d cycle", addr, cycles);
         stop_on_error();
      end
      rdata = host_rdata_o;
   endtask

   task automatic do_access(input logic [ADDR_W-1:0] addr, input logic [NUM_COL-1:0] wstrb,
                            input logic [DATA_W-1:0] wdata);
      logic [DATA_W-1:0]  old_word;
      logic [DATA_W-1:0]  rdata;
      logic [NUM_COL-1:0] strobe;
      logic               was_known;
      strobe = wstrb;
      // unwritten words get filled whole on first touch
      if (!known[addr] && strobe != '1) begin
         strobe = '1;
      end
      old_word  = model[addr];
      was_known = known[addr];
      host_access(addr, strobe, wdata, rdata);
      if (was_known) begin
         check("host_rdata_o", rdata, old_word);
      end
      for (int k = 0; k < NUM_COL; k++) begin
         if (strobe[k]) begin
            model[addr][k*COL_W +: COL_W] = wdata[k*COL_W +: COL_W];
         end
      end
      if (strobe != '0) begin
         known[addr] = 1'b1;
      end
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired after %0d ns, test sequence did not finish", TIMEOUT_NS);
      stop_on_error();
   end

   initial begin
      logic [31:0]        r;
      logic [31:0]        data;
      logic [ADDR_W-1:0]  addr;
      logic [NUM_COL-1:0] strobe;
      reset_i      = 1'b1;
      host_valid_i = 1'b0;
      host_addr_i  = '0;
      host_wdata_i = '0;
      host_wstrb_i = '0;
      lfsr_q       = 32'ha7dd;
      error_count  = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         model[i] = '0;
         known[i] = 1'b0;
      end
      load_boot_model();

      apply_reset();
      wait_boot_done(BOOT_WORDS + 4);
      for (int i = 0; i < BOOT_WORDS; i++) begin
         do_access(ADDR_W'(i), '0, '0);
      end

      // full words each read back
      for (int i = 0; i < N_FULL; i++) begin
         rand_high_addr(addr);
         data = rand_bits(DATA_W);
         full_addr[i] = addr;
         do_access(addr, '1, data);
         do_access(addr, '0, '0);
      end

      for (int i = 0; i < N_BYTE; i++) begin
         r = rand_bits(8);
         addr = full_addr[int'(r % N_FULL)];
         r = rand_bits(NUM_COL);
         strobe = r[NUM_COL-1:0];
         if (strobe == '0) begin
            strobe = 4'b0001;
         end
         data = rand_bits(DATA_W);
         do_access(addr, strobe, data);
         do_access(addr, '0, '0);
      end

      // host traffic while the copier refills the boot region
      apply_reset();
      load_boot_model();
      for (int i = 0; i < N_CONT / 2; i++) begin
         rand_high_addr(addr);
         data = rand_bits(DATA_W);
         do_access(addr, '1, data);
         do_access(addr, '0, '0);
      end
      wait_boot_done(2 * (BOOT_WORDS + 4));
      for (int i = 0; i < BOOT_WORDS; i++) begin
         do_access(ADDR_W'(i), '0, '0);
      end

      for (int i = 0; i < N_RANDOM; i++) begin
         r = rand_bits(ADDR_W);
         addr = r[ADDR_W-1:0];
         r = rand_bits(1);
         if (r[0]) begin
            r = rand_bits(NUM_COL);
            strobe = r[NUM_COL-1:0];
         end else begin
            strobe = '0;
         end
         data = rand_bits(DATA_W);
         do_access(addr, strobe, data);
      end

      if (error_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- verilog.f
hdl/soc_mem_pkg.sv
hdl/mem_bus_if.sv
hdl/byte_ram_sp.sv
hdl/mem_arbiter.sv
hdl/boot_copier.sv
hdl/host_port.sv
hdl/soc_mem_top.sv
bench/soc_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module soc_mem_tb -f verilog.f -Mdir obj_dir -o soc_mem_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/soc_mem_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulator exited with status $run_status"
   exit 1
fi

echo "simulation finished cleanly"
exit 0
